// File: seg_cfg.svh
`ifndef SEG_CFG_SVH
`define SEG_CFG_SVH

// Number of seven-segment digits on the board
`define SEG_DIGITS 8

// Segments per digit without the decimal point
`define SEG_WIDTH 7

// Slide switches read back through the switch window
`define SEG_SW_WIDTH 10

// The low nibble of a digit code is the hex value and the top bit blanks it
`define SEG_CODE_WIDTH 5

// Wishbone classic bus widths
`define SEG_ADR_WIDTH 32
`define SEG_DAT_WIDTH 32

`endif

// File: seg_pkg.sv
`default_nettype none

`include "seg_cfg.svh"

package seg_pkg;

  // Code held per digit where bit 4 set means the digit is dark
  typedef logic [`SEG_CODE_WIDTH-1:0] digit_code_t;

  // Bit 0 is segment a up to bit 6 for segment g, a one lights the segment
  typedef logic [`SEG_WIDTH-1:0] seg_pattern_t;

  // Slave cycle state with one wait state before the acknowledge
  typedef enum logic
  {
    ST_IDLE,
    ST_ACK
  } bus_state_e;

endpackage

`default_nettype wire

// File: hex_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "seg_cfg.svh"

module hex_decoder (
  input  seg_pkg::digit_code_t  code_i,
  output seg_pkg::seg_pattern_t seg_o
);
  import seg_pkg::*;

  // One mask per segment so the table below reads like the datasheet
  localparam seg_pattern_t SEG_A = seg_pattern_t'(7'b0000001);
  localparam seg_pattern_t SEG_B = seg_pattern_t'(7'b0000010);
  localparam seg_pattern_t SEG_C = seg_pattern_t'(7'b0000100);
  localparam seg_pattern_t SEG_D = seg_pattern_t'(7'b0001000);
  localparam seg_pattern_t SEG_E = seg_pattern_t'(7'b0010000);
  localparam seg_pattern_t SEG_F = seg_pattern_t'(7'b0100000);
  localparam seg_pattern_t SEG_G = seg_pattern_t'(7'b1000000);

  localparam int BLANK_BIT = `SEG_CODE_WIDTH - 1;

  logic [3:0] hex_val;
  logic       blank;

  assign hex_val = code_i[3:0];
  assign blank   = code_i[BLANK_BIT];

  always_comb
  begin
    if (blank)
    begin
      seg_o = '0; // Whole digit dark
    end
    else
    begin
      case (hex_val)
        4'h0: seg_o = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F;
        4'h1: seg_o = SEG_B | SEG_C;
        4'h2: seg_o = SEG_A | SEG_B | SEG_D | SEG_E | SEG_G;
        4'h3: seg_o = SEG_A | SEG_B | SEG_C | SEG_D | SEG_G;
        4'h4: seg_o = SEG_B | SEG_C | SEG_F | SEG_G;
        4'h5: seg_o = SEG_A | SEG_C | SEG_D | SEG_F | SEG_G;
        4'h6: seg_o = SEG_A | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
        4'h7: seg_o = SEG_A | SEG_B | SEG_C;
        4'h8: seg_o = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
        4'h9: seg_o = SEG_A | SEG_B | SEG_C | SEG_D | SEG_F | SEG_G;
        // Letters use the usual mixed case shapes with b and d in lower case
        4'hA: seg_o = SEG_A | SEG_B | SEG_C | SEG_E | SEG_F | SEG_G;
        4'hB: seg_o = SEG_C | SEG_D | SEG_E | SEG_F | SEG_G;
        4'hC: seg_o = SEG_A | SEG_D | SEG_E | SEG_F;
        4'hD: seg_o = SEG_B | SEG_C | SEG_D | SEG_E | SEG_G;
        4'hE: seg_o = SEG_A | SEG_D | SEG_E | SEG_F | SEG_G;
        4'hF: seg_o = SEG_A | SEG_E | SEG_F | SEG_G;
        default: seg_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: seg_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "seg_cfg.svh"

module seg_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,

  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [`SEG_ADR_WIDTH-1:0] adr_i,
  input  logic [`SEG_DAT_WIDTH-1:0] dat_i,
  output logic                      ack_o,
  output logic [`SEG_DAT_WIDTH-1:0] dat_o,

  input  logic [`SEG_SW_WIDTH-1:0]  sw_i,

  output seg_pkg::seg_pattern_t     seg_o [`SEG_DIGITS]
);
  import seg_pkg::*;

  // Word address with bits 1..0 ignored
  localparam int IDX_W   = $clog2(`SEG_DIGITS);
  localparam int IDX_LSB = 2;
  localparam int IDX_MSB = IDX_LSB + IDX_W - 1;
  localparam int WIN_BIT = IDX_MSB + 1; // High selects the switch window

  bus_state_e                state_q;
  bus_state_e                state_d;

  digit_code_t               digit_q [`SEG_DIGITS];
  digit_code_t               digit_d [`SEG_DIGITS];

  logic [`SEG_DAT_WIDTH-1:0] dat_q;
  logic [`SEG_DAT_WIDTH-1:0] dat_d;

  logic [`SEG_SW_WIDTH-1:0]  sw_meta_q;
  logic [`SEG_SW_WIDTH-1:0]  sw_sync_q;

  logic                      bus_req;
  logic                      sw_win;
  logic [IDX_W-1:0]          digit_sel;

  assign bus_req   = cyc_i && stb_i;
  assign sw_win    = adr_i[WIN_BIT];
  assign digit_sel = adr_i[IDX_MSB:IDX_LSB];

  // Acknowledge is the wait state itself, so it lasts exactly one cycle
  assign ack_o = (state_q == ST_ACK);
  assign dat_o = dat_q;

  // Switches come straight from the board pins
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end
    else
    begin
      sw_meta_q <= sw_i;
      sw_sync_q <= sw_meta_q;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_IDLE;
      dat_q   <= '0;
      for (int i = 0; i < `SEG_DIGITS; i++)
      begin
        digit_q[i] <= '0; // Every digit starts out showing 0
      end
    end
    else
    begin
      state_q <= state_d;
      dat_q   <= dat_d;
      for (int i = 0; i < `SEG_DIGITS; i++)
      begin
        digit_q[i] <= digit_d[i];
      end
    end
  end

  always_comb
  begin
    state_d = state_q;
    dat_d   = dat_q; // Read data holds until the next accepted read
    for (int i = 0; i < `SEG_DIGITS; i++)
    begin
      digit_d[i] = digit_q[i];
    end

    case (state_q)
      ST_IDLE:
      begin
        if (bus_req)
        begin
          if (sw_win)
          begin
            // Writes here are acknowledged and dropped
            if (!we_i)
            begin
              dat_d = '0;
              dat_d[`SEG_SW_WIDTH-1:0] = sw_sync_q;
            end
          end
          else if (we_i)
          begin
            digit_d[digit_sel] = dat_i[`SEG_CODE_WIDTH-1:0];
          end
          else
          begin
            dat_d = '0;
            dat_d[`SEG_CODE_WIDTH-1:0] = digit_q[digit_sel];
          end
          state_d = ST_ACK;
        end
      end

      // Strobe is not looked at here so a held strobe waits one cycle
      ST_ACK:
      begin
        state_d = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // Decoders are combinational so a write shows up during the ack cycle
  for (genvar g = 0; g < `SEG_DIGITS; g++)
  begin : g_digit
    hex_decoder u_hex_decoder (
      .code_i (digit_q[g]),
      .seg_o  (seg_o[g])
    );
  end

endmodule

`default_nettype wire

// File: seg_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "seg_cfg.svh"

module seg_top (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Wishbone classic slave
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [`SEG_ADR_WIDTH-1:0] adr_i,
  input  logic [`SEG_DAT_WIDTH-1:0] dat_i,
  output logic                      ack_o,
  output logic [`SEG_DAT_WIDTH-1:0] dat_o,

  // Board slide switches
  input  logic [`SEG_SW_WIDTH-1:0]  sw_i,

  // Digit 0 is the rightmost display on the board
  output seg_pkg::seg_pattern_t     digit0_o,
  output seg_pkg::seg_pattern_t     digit1_o,
  output seg_pkg::seg_pattern_t     digit2_o,
  output seg_pkg::seg_pattern_t     digit3_o,
  output seg_pkg::seg_pattern_t     digit4_o,
  output seg_pkg::seg_pattern_t     digit5_o,
  output seg_pkg::seg_pattern_t     digit6_o,
  output seg_pkg::seg_pattern_t     digit7_o
);
  import seg_pkg::*;

  seg_pattern_t digit_seg [`SEG_DIGITS];

  seg_ctrl u_seg_ctrl (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .ack_o (ack_o),
    .dat_o (dat_o),
    .sw_i  (sw_i),
    .seg_o (digit_seg)
  );

  // Break the array out onto the named display pins
  assign digit0_o = digit_seg[0];
  assign digit1_o = digit_seg[1];
  assign digit2_o = digit_seg[2];
  assign digit3_o = digit_seg[3];
  assign digit4_o = digit_seg[4];
  assign digit5_o = digit_seg[5];
  assign digit6_o = digit_seg[6];
  assign digit7_o = digit_seg[7];

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // 4 ns period
  end

  // Reset covers the first two rising edges
  initial
  begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_seg_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "seg_cfg.svh"

module tb_seg_top;
  import seg_pkg::*;

  localparam int          CYCLE_LIMIT = 4000;
  localparam logic [31:0] SW_ADR      = 32'h0000_0020;

  logic                                clk, rst, cyc, stb, we, ack;
  logic [`SEG_ADR_WIDTH-1:0]           adr;
  logic [`SEG_DAT_WIDTH-1:0]           wdat, rdat;
  logic [`SEG_SW_WIDTH-1:0]            sw;
  wire  [`SEG_DIGITS*`SEG_WIDTH-1:0]   digits_flat;
  logic [`SEG_DIGITS*`SEG_WIDTH-1:0]   seen_seg; // Digit outputs captured in the ack cycle
  digit_code_t                         model [`SEG_DIGITS];
  logic [15:0]                         lfsr_state;
  logic                                req_prev, ack_prev;
  int                                  errors, checks, timeouts, cycle_cnt, ack_cnt;
  logic [31:0]                         r_idx, r_code, r_hi, r_lo, r_dat;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  seg_top UUT (
    .clk_i (clk), .rst_i (rst),
    .cyc_i (cyc), .stb_i (stb), .we_i (we), .adr_i (adr), .dat_i (wdat),
    .ack_o (ack), .dat_o (rdat), .sw_i (sw),
    .digit0_o (digits_flat[6:0]),   .digit1_o (digits_flat[13:7]),
    .digit2_o (digits_flat[20:14]), .digit3_o (digits_flat[27:21]),
    .digit4_o (digits_flat[34:28]), .digit5_o (digits_flat[41:35]),
    .digit6_o (digits_flat[48:42]), .digit7_o (digits_flat[55:49])
  );

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    begin
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
    end
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    begin
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
        lfsr_state = lfsr_step(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
      end
    end
  endtask

  // Segment a is bit 0, segment g is bit 6
  function automatic seg_pattern_t pattern_of(input digit_code_t code);
    seg_pattern_t pat;
    begin
      case (code[3:0])
        4'h0: pat = 7'h3F;
        4'h1: pat = 7'h06;
        4'h2: pat = 7'h5B;
        4'h3: pat = 7'h4F;
        4'h4: pat = 7'h66;
        4'h5: pat = 7'h6D;
        4'h6: pat = 7'h7D;
        4'h7: pat = 7'h07;
        4'h8: pat = 7'h7F;
        4'h9: pat = 7'h6F;
        4'hA: pat = 7'h77;
        4'hB: pat = 7'h7C;
        4'hC: pat = 7'h39;
        4'hD: pat = 7'h5E;
        4'hE: pat = 7'h79;
        default: pat = 7'h71;
      endcase
      if (code[4])
        pat = '0;
      return pat;
    end
  endfunction

  task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    begin
      checks++;
      assert (got === exp)
      else
      begin
        errors++;
        $display("[FAIL] %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
    end
  endtask

  // Entered 1 ns after a rising edge and returns 1 ns after the edge that ends the ack cycle
  task automatic bus_xfer(input logic [31:0] a, input logic wr, input logic [31:0] d,
                          output logic [31:0] rd);
    begin
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = wr;
      adr  = a;
      wdat = d;
      @(negedge clk);
      while (ack !== 1'b1)
      begin
        @(negedge clk);
      end
      rd       = rdat;
      seen_seg = digits_flat;
      @(posedge clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
    end
  endtask

  task automatic check_digits(input string when_msg);
    begin
      for (int i = 0; i < `SEG_DIGITS; i++)
      begin
        expect_eq(32'(seen_seg[i*`SEG_WIDTH +: `SEG_WIDTH]), 32'(pattern_of(model[i])),
                  $sformatf("%s, digit %0d", when_msg, i));
      end
    end
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] rd_dummy;
    begin
      bus_xfer(a, 1'b1, d, rd_dummy);
      if (!a[5])
        model[a[4:2]] = d[`SEG_CODE_WIDTH-1:0]; // Switch window writes are dropped
      check_digits($sformatf("write %h to %h", d, a));
    end
  endtask

  task automatic read_reg(input logic [31:0] a);
    logic [31:0] rd;
    logic [31:0] exp;
    begin
      exp = '0;
      if (a[5])
        exp[`SEG_SW_WIDTH-1:0] = sw;
      else
        exp[`SEG_CODE_WIDTH-1:0] = model[a[4:2]];
      bus_xfer(a, 1'b0, 32'h0, rd);
      expect_eq(rd, exp, $sformatf("read from %h", a));
    end
  endtask

  task automatic finish_run();
    begin
      $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
        $display("PASS: all tests");
      else
        $display("FAIL: see errors above");
      $finish;
    end
  endtask

  // Ack must follow each accepted request by one cycle, and only then
  always @(negedge clk)
  begin
    if (rst)
    begin
      req_prev = 1'b0;
      ack_prev = 1'b0;
    end
    else
    begin
      expect_eq(32'(ack), 32'(req_prev && !ack_prev), "ack_o against handshake model");
      assert (!(ack && ack_prev))
      else
      begin
        errors++;
        $display("Protocol error at %0t: ack_o was high on two cycles in a row", $time);
      end
      req_prev = cyc && stb;
      ack_prev = ack;
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    timeouts++;
    finish_run();
  end

  initial
  begin
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    wdat = '0;
    sw = '0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    lfsr_state = 16'd30204;
    for (int i = 0; i < `SEG_DIGITS; i++)
      model[i] = '0;
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    @(posedge clk);
    #1;

    // Reset state
    expect_eq(32'(ack), 32'h0, "ack_o after reset");
    expect_eq(rdat, 32'h0, "dat_o after reset");
    seen_seg = digits_flat;
    check_digits("after reset");
    for (int i = 0; i < `SEG_DIGITS; i++)
      read_reg(32'(i) << 2);

    // Every code through the decoder, blanking codes included
    for (int code = 0; code < 32; code++)
      write_reg(32'(code % `SEG_DIGITS) << 2, 32'(code));

    for (int n = 0; n < 64; n++)
    begin
      take_bits(3, r_idx);
      take_bits(5, r_code);
      take_bits(27, r_hi);
      write_reg({27'b0, r_idx[2:0], 2'b00}, {r_hi[26:0], r_code[4:0]});
      for (int k = 0; k < 2; k++)
      begin
        take_bits(3, r_idx);
        read_reg({27'b0, r_idx[2:0], 2'b00});
      end
    end

    // Switch value is held long enough to pass the synchronizer
    for (int n = 0; n < 4; n++)
    begin
      take_bits(`SEG_SW_WIDTH, r_dat);
      sw = r_dat[`SEG_SW_WIDTH-1:0];
      repeat (3) @(posedge clk);
      #1;
      read_reg(SW_ADR);
      take_bits(32, r_dat);
      write_reg(SW_ADR, r_dat);
    end

    // Strobe held across back to back reads
    take_bits(3, r_idx);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = {27'b0, r_idx[2:0], 2'b00};
    ack_cnt = 0;
    repeat (12)
    begin
      @(negedge clk);
      if (ack)
      begin
        ack_cnt++;
        expect_eq(rdat, 32'(model[r_idx[2:0]]), "held strobe read data");
      end
    end
    @(posedge clk);
    #1;
    expect_eq(32'(ack_cnt), 32'd6, "acks during held strobe");
    cyc = 1'b0;
    ack_cnt = 0;
    repeat (6)
    begin
      @(negedge clk);
      if (ack)
        ack_cnt++;
    end
    @(posedge clk);
    #1;
    stb = 1'b0;
    expect_eq(32'(ack_cnt), 32'd0, "acks for strobe without cyc_i");

    // Unused address bits must not move the target register
    for (int n = 0; n < 8; n++)
    begin
      take_bits(3, r_idx);
      take_bits(26, r_hi);
      take_bits(2, r_lo);
      take_bits(5, r_code);
      write_reg({r_hi[25:0], 1'b0, r_idx[2:0], r_lo[1:0]}, 32'(r_code[4:0]));
      take_bits(26, r_hi);
      take_bits(2, r_lo);
      read_reg({r_hi[25:0], 1'b0, r_idx[2:0], r_lo[1:0]});
    end

    finish_run();
  end

endmodule

`default_nettype wire

// File: seg_periph.f
+incdir+.
seg_pkg.sv
hex_decoder.sv
seg_ctrl.sv
seg_top.sv
tb_clk_gen.sv
tb_seg_top.sv

// File: Bender.yml
package:
  name: seg_periph

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - seg_pkg.sv
      - hex_decoder.sv
      - seg_ctrl.sv
      - seg_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_seg_top.sv
